/* verilog/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;                // Data or byte address word
    typedef logic [4:0]  reg_addr_t;            // Register number
    typedef logic [2:0]  op_t;                  // Compact operation code from execute

    // Operation codes, 5 to 7 are illegal
    localparam op_t OP_NOP   = 3'd0;            // Bubble, no side effect
    localparam op_t OP_ALU   = 3'd1;            // Write ALU result to dest
    localparam op_t OP_LOAD  = 3'd2;            // Read RAM word into dest
    localparam op_t OP_STORE = 3'd3;            // Write store data to RAM
    localparam op_t OP_LINK  = 3'd4;            // Write return address to dest

endpackage

/* verilog/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control
    import cpu_pkg::*;
(
    input  logic clk,                           // Only clocks the legality check
    input  logic rst,                           // Only disables the legality check
    input  op_t  op,                            // Operation code from execute
    output logic mem_read,                      // Load from data RAM
    output logic mem_write,                     // Store to data RAM
    output logic mem_to_reg,                    // Write back the RAM word
    output logic reg_write,                     // Operation writes a register
    output logic reg_data_src                   // Write back the link value
);

    always_comb
    begin
        mem_read     = 1'b0;                    // Everything off unless decoded
        mem_write    = 1'b0;
        mem_to_reg   = 1'b0;
        reg_write    = 1'b0;
        reg_data_src = 1'b0;
        case (op)
            OP_ALU:
            begin
                reg_write = 1'b1;               // ALU result goes to dest
            end
            OP_LOAD:
            begin
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;              // Select loaded word in writeback
                reg_write  = 1'b1;
            end
            OP_STORE:
            begin
                mem_write = 1'b1;               // No register write for stores
            end
            OP_LINK:
            begin
                reg_write    = 1'b1;
                reg_data_src = 1'b1;            // Return address instead of ALU result
            end
            default:
            begin
                mem_read = 1'b0;                // NOP and illegal codes do nothing
            end
        endcase
    end

    // Execute must never hand over codes 5 to 7
    a_op_legal: assert property (
        @(posedge clk) disable iff (rst) op <= OP_LINK
    ) else $error("pipe_control: illegal operation code %0d", op);

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import cpu_pkg::*;
#(
    parameter int RAM_ADDR_W = 8                // Word-address bits of the data RAM
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  word_t                 alu_result,       // Effective address or ALU value
    input  word_t                 store_data,       // Word to store
    input  word_t                 link_value,       // Return address
    input  reg_addr_t             dest,             // Destination register
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  mem_to_reg,
    input  logic                  reg_write,
    input  logic                  reg_data_src,
    input  logic                  branch_taken,
    output logic [RAM_ADDR_W-1:0] mem_addr,         // Word index into data RAM
    output word_t                 mem_write_data,
    output logic                  mem_write_enable,
    output word_t                 mem_result,       // Registered ALU result
    output word_t                 mem_link,         // Registered link value
    output reg_addr_t             mem_dest,
    output logic                  mem_mem_to_reg,
    output logic                  mem_reg_write,
    output logic                  mem_reg_data_src,
    output logic                  mem_done,         // One cycle after a load or store
    output logic                  pc_redirect       // Taken branch seen by fetch
);

    word_t     alu_q;                           // Payload, no reset needed
    word_t     store_q;
    word_t     link_q;
    reg_addr_t dest_q;

    always_ff @(posedge clk)
    begin
        alu_q   <= alu_result;
        store_q <= store_data;
        link_q  <= link_value;
        dest_q  <= dest;
    end

    // Control bits all advance on the same edge as the payload
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mem_write_enable <= 1'b0;
            mem_done         <= 1'b0;
            pc_redirect      <= 1'b0;
            mem_mem_to_reg   <= 1'b0;
            mem_reg_write    <= 1'b0;
            mem_reg_data_src <= 1'b0;
        end
        else
        begin
            mem_write_enable <= mem_write;      // RAM write lands at the next edge
            mem_done         <= mem_read | mem_write;
            pc_redirect      <= branch_taken;
            mem_mem_to_reg   <= mem_to_reg;
            mem_reg_write    <= reg_write;
            mem_reg_data_src <= reg_data_src;
        end
    end

    assign mem_addr       = alu_q[RAM_ADDR_W+1:2];  // Byte offset dropped
    assign mem_write_data = store_q;
    assign mem_result     = alu_q;
    assign mem_link       = link_q;
    assign mem_dest       = dest_q;

    // Decoder must never ask for a load and a store at once
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst) !(mem_read && mem_write)
    ) else $error("mem_stage: mem_read and mem_write both high");

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import cpu_pkg::*;
#(
    parameter int RAM_ADDR_W = 8                // Word-address bits
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [RAM_ADDR_W-1:0] mem_addr,         // Word index
    input  word_t                 mem_write_data,
    input  logic                  mem_write_enable,
    output word_t                 mem_read_data     // Combinational read
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;     // Words in the array

    word_t mem [DEPTH];

    // Cleared on reset so loads of untouched words return zero
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (mem_write_enable)
        begin
            mem[mem_addr] <= mem_write_data;    // Single word write port
        end
    end

    // Read is asynchronous, a write shows from the edge after it
    assign mem_read_data = mem[mem_addr];

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     mem_result,               // ALU result from memory stage
    input  word_t     mem_link,                 // Return address
    input  word_t     mem_read_data,            // Word read from data RAM
    input  reg_addr_t mem_dest,
    input  logic      mem_mem_to_reg,           // Pick loaded word
    input  logic      mem_reg_write,
    input  logic      mem_reg_data_src,         // Pick link value
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata
);

    word_t wb_value;                            // Value chosen for the register file

    // Load has priority, then link, else plain ALU result
    always_comb
    begin
        if (mem_mem_to_reg)
            wb_value = mem_read_data;
        else if (mem_reg_data_src)
            wb_value = mem_link;
        else
            wb_value = mem_result;
    end

    always_ff @(posedge clk)
    begin
        rf_waddr <= mem_dest;                   // Register 0 passed on as is
        rf_wdata <= wb_value;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rf_we <= 1'b0;
        else
            rf_we <= mem_reg_write;
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rf_we,                    // Write strobe from writeback
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    input  reg_addr_t rd_addr,                  // Debug read address
    output word_t     rd_data
);

    word_t regs [1:31];                         // Register 0 has no storage

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rf_we && (rf_waddr != '0))
        begin
            regs[rf_waddr] <= rf_wdata;         // Writes to register 0 dropped here
        end
    end

    // Register 0 always reads zero
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

/* verilog/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top
    import cpu_pkg::*;
#(
    parameter int RAM_ADDR_W = 8                // Data RAM size in word-address bits
)
(
    input  logic      clk,
    input  logic      rst,
    input  op_t       op,                       // Operation code from execute
    input  word_t     alu_result,
    input  word_t     store_data,
    input  word_t     link_value,
    input  reg_addr_t dest,
    input  logic      branch_taken,
    input  reg_addr_t rd_addr,                  // Debug register read
    output word_t     rd_data,
    output logic      rf_we,                    // Copy of register-file write port
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      mem_done,
    output logic      pc_redirect
);

    logic                  mem_read, mem_write, mem_to_reg, reg_write, reg_data_src;
    logic [RAM_ADDR_W-1:0] mem_addr;
    word_t                 mem_write_data;
    logic                  mem_write_enable;
    word_t                 mem_read_data;
    word_t                 mem_result;
    word_t                 mem_link;
    reg_addr_t             mem_dest;
    logic                  mem_mem_to_reg, mem_reg_write, mem_reg_data_src;

    pipe_control u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_to_reg   (mem_to_reg),
        .reg_write    (reg_write),
        .reg_data_src (reg_data_src)
    );

    mem_stage #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_mem (
        .clk              (clk),
        .rst              (rst),
        .alu_result       (alu_result),
        .store_data       (store_data),
        .link_value       (link_value),
        .dest             (dest),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_to_reg       (mem_to_reg),
        .reg_write        (reg_write),
        .reg_data_src     (reg_data_src),
        .branch_taken     (branch_taken),
        .mem_addr         (mem_addr),
        .mem_write_data   (mem_write_data),
        .mem_write_enable (mem_write_enable),
        .mem_result       (mem_result),
        .mem_link         (mem_link),
        .mem_dest         (mem_dest),
        .mem_mem_to_reg   (mem_mem_to_reg),
        .mem_reg_write    (mem_reg_write),
        .mem_reg_data_src (mem_reg_data_src),
        .mem_done         (mem_done),
        .pc_redirect      (pc_redirect)
    );

    data_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .clk              (clk),
        .rst              (rst),
        .mem_addr         (mem_addr),
        .mem_write_data   (mem_write_data),
        .mem_write_enable (mem_write_enable),
        .mem_read_data    (mem_read_data)
    );

    writeback_stage u_wb (
        .clk              (clk),
        .rst              (rst),
        .mem_result       (mem_result),
        .mem_link         (mem_link),
        .mem_read_data    (mem_read_data),
        .mem_dest         (mem_dest),
        .mem_mem_to_reg   (mem_mem_to_reg),
        .mem_reg_write    (mem_reg_write),
        .mem_reg_data_src (mem_reg_data_src),
        .rf_we            (rf_we),
        .rf_waddr         (rf_waddr),
        .rf_wdata         (rf_wdata)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // A finished load must reach the register-file port on the next cycle
    a_load_writes: assert property (
        @(posedge clk) disable iff (rst)
        (mem_done && mem_mem_to_reg) |=> (rf_we && (rf_wdata == $past(mem_read_data)))
    ) else $error("mem_wb_top: load result lost before writeback");

endmodule

/* sim/mem_wb_tb.sv */
`timescale 1ns/1ps

module mem_wb_tb
    import cpu_pkg::*;
();

    logic        clk;
    logic        rst;
    op_t         op;
    word_t       alu_result;
    word_t       store_data;
    word_t       link_value;
    reg_addr_t   dest;
    logic        branch_taken;
    reg_addr_t   rd_addr;
    word_t       rd_data;
    logic        rf_we;
    reg_addr_t   rf_waddr;
    word_t       rf_wdata;
    logic        mem_done;
    logic        pc_redirect;

    word_t       ram_model [256];               // Reference data RAM
    word_t       regs_model [32];               // Reference registers where r0 stays zero
    logic [33:0] strobe_q [$];                  // {check edge, mem_done, pc_redirect}
    logic [69:0] port_q [$];                    // {check edge, rf_we, rf_waddr, rf_wdata}
    int unsigned edge_cnt;                      // Rising edges seen so far
    word_t       lfsr;
    reg_addr_t   rd_sel;                        // Debug read address held while driving
    logic        checking;
    int          check_cnt, err_cnt, test_cnt, failed_cnt, test_err_base;

    mem_wb_top #(.RAM_ADDR_W (8)) DUT (.*);

    always #20 clk = ~clk;                      // 40 ns period

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32 22 2 1
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t window_addr();
        word_t idx;
        word_t off;
        idx = rand_bits(4);
        off = rand_bits(2);
        return 32'h0000_0100 + (idx << 2) + off;    // Words 64 to 79 plus a random byte offset
    endfunction

    // Applies one operation to the model in issue order and returns the write-back value
    function automatic word_t apply_to_model(input op_t c, input word_t alu,
                                             input word_t sdata, input word_t link,
                                             input reg_addr_t d);
        word_t value;
        value = alu;
        if (c == OP_LOAD)
            value = ram_model[alu[9:2]];        // Word index without the byte offset
        else if (c == OP_LINK)
            value = link;
        else if (c == OP_STORE)
            ram_model[alu[9:2]] = sdata;
        if ((c == OP_ALU || c == OP_LOAD || c == OP_LINK) && d != 5'd0)
            regs_model[d] = value;
        return value;
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        check_cnt++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic issue(input op_t c, input word_t alu, input word_t sdata, input word_t link,
                         input reg_addr_t d, input logic br);
        word_t value;
        @(posedge clk);
        #2;
        op           = c;
        alu_result   = alu;
        store_data   = sdata;
        link_value   = link;
        dest         = d;
        branch_taken = br;
        rd_addr      = rd_sel;
        value = apply_to_model(c, alu, sdata, link, d);
        strobe_q.push_back({edge_cnt + 32'd1, c == OP_LOAD || c == OP_STORE, br});
        port_q.push_back({edge_cnt + 32'd2, c == OP_ALU || c == OP_LOAD || c == OP_LINK,
                          d, value});           // Port valid in the cycle after edge k+1
    endtask

    task automatic park();
        @(posedge clk);
        #2;
        op           = OP_NOP;
        branch_taken = 1'b0;
        rd_addr      = rd_sel;
    endtask

    task automatic drain();
        int waited;
        park();
        waited = 0;
        while ((strobe_q.size() > 0 || port_q.size() > 0) && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (strobe_q.size() > 0 || port_q.size() > 0)
        begin
            $display("Error at %0t: pipeline results still pending after 20 cycles", $time);
            err_cnt++;
            strobe_q.delete();                  // Stale entries would shift later checks
            port_q.delete();
        end
    endtask

    task automatic check_reg(input reg_addr_t a);
        rd_sel = a;
        park();
        @(negedge clk);
        check_value($sformatf("rd_data of r%0d", a), rd_data, regs_model[a]);
    endtask

    // Random legal code with loads and stores inside the window
    task automatic random_op();
        word_t r;
        word_t alu;
        op_t   c;
        r = rand_bits(3);
        c = (r[2:0] > 3'd4) ? r[2:0] - 3'd4 : r[2:0];  // Fold 5..7 onto 1..3
        if (c == OP_LOAD || c == OP_STORE)
            alu = window_addr();
        else
            alu = rand_bits(32);
        issue(c, alu, rand_bits(32), rand_bits(32), reg_addr_t'(rand_bits(5)), rand_bits(1) != 0);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base)
            $display("Test %0d %s: ok", test_cnt, name);
        else
        begin
            failed_cnt++;
            $display("Test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // Strobes one edge and the write port two edges after each operation and zero when idle
    always @(negedge clk)
    begin
        logic [33:0] s;
        logic [69:0] p;
        if (checking)
        begin
            s = '0;
            p = '0;
            if (strobe_q.size() > 0 && strobe_q[0][33:2] == edge_cnt)
                s = strobe_q.pop_front();
            if (port_q.size() > 0 && port_q[0][69:38] == edge_cnt)
                p = port_q.pop_front();
            check_value("mem_done", 32'(mem_done), 32'(s[1]));
            check_value("pc_redirect", 32'(pc_redirect), 32'(s[0]));
            check_value("rf_we", 32'(rf_we), 32'(p[37]));
            if (p[37])
            begin
                check_value("rf_waddr", 32'(rf_waddr), 32'(p[36:32]));
                check_value("rf_wdata", rf_wdata, p[31:0]);
            end
        end
    end

    initial
    begin
        reg_addr_t d;
        word_t     old;
        word_t     a;
        word_t     addrs [8];
        clk          = 1'b0;
        rst          = 1'b1;
        op           = OP_NOP;
        alu_result   = '0;
        store_data   = '0;
        link_value   = '0;
        dest         = '0;
        branch_taken = 1'b0;
        rd_addr      = '0;
        rd_sel       = '0;
        edge_cnt     = 0;
        lfsr         = 32'h8a57ab42;
        checking     = 1'b0;
        check_cnt     = 0;
        err_cnt       = 0;
        test_cnt      = 0;
        failed_cnt    = 0;
        test_err_base = 0;
        for (int i = 0; i < 256; i++)
            ram_model[i] = '0;
        for (int i = 0; i < 32; i++)
            regs_model[i] = '0;
        repeat (10) @(posedge clk);             // Reset for 10 cycles
        #2;
        rst      = 1'b0;
        checking = 1'b1;

        for (int i = 0; i < 32; i++)
            check_reg(reg_addr_t'(i));          // Strobes low and every register zero
        end_test("reset state");

        for (int i = 0; i < 8; i++)
        begin
            d      = reg_addr_t'(rand_bits(5) | 32'd1);     // Never r0
            old    = regs_model[d];
            rd_sel = d;
            issue((i % 2 == 0) ? OP_ALU : OP_LINK, rand_bits(32), rand_bits(32), rand_bits(32),
                  d, 1'b0);
            park();
            @(negedge clk);
            @(negedge clk);
            check_value("rd_data before write", rd_data, old);      // Port valid but not written
            @(negedge clk);
            check_value("rd_data after write", rd_data, regs_model[d]);
        end
        drain();
        end_test("alu and link writes");

        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = window_addr();
            issue(OP_STORE, addrs[i], rand_bits(32), rand_bits(32), 5'd3, 1'b0);
        end
        for (int i = 7; i >= 0; i--)
            issue(OP_LOAD, addrs[i] ^ 32'd3, '0, '0, reg_addr_t'(i + 8), 1'b0);
        for (int i = 0; i < 8; i++)
        begin
            a = window_addr();
            issue(OP_STORE, a, rand_bits(32), rand_bits(32), 5'd0, 1'b0);
            issue(OP_LOAD, a, '0, '0, reg_addr_t'(i + 16), 1'b0);   // Back to back with store
            issue(OP_NOP, a, rand_bits(32), rand_bits(32), 5'd7, 1'b0);
        end
        drain();
        for (int i = 8; i < 24; i++)
            check_reg(reg_addr_t'(i));
        end_test("store then load");

        issue(OP_ALU, 32'hdead_beef, '0, '0, 5'd0, 1'b0);
        issue(OP_LINK, '0, '0, 32'h1234_5678, 5'd0, 1'b0);
        issue(OP_LOAD, addrs[0], '0, '0, 5'd0, 1'b0);
        drain();
        check_reg(5'd0);
        end_test("register zero");

        for (int i = 0; i < 40; i++)
            issue(op_t'(i % 5), window_addr(), rand_bits(32), rand_bits(32),
                  reg_addr_t'(rand_bits(5)), rand_bits(1) != 0);
        drain();
        end_test("strobes");

        for (int i = 0; i < 300; i++)
            random_op();
        drain();
        for (int i = 0; i < 32; i++)
            check_reg(reg_addr_t'(i));          // Final register dump
        end_test("random stream");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, failed_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* sim.f */
verilog/cpu_pkg.sv
verilog/pipe_control.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/writeback_stage.sv
verilog/reg_file.sv
verilog/mem_wb_top.sv
sim/mem_wb_tb.sv

/* Makefile */
VERILATOR = verilator
TOP       = mem_wb_tb
FILELIST  = sim.f
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
